// ==== Makefile ====
# Verilator build and run of the scope display testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := scope_display_tb
FILELIST  := scope_display.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := TEST PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass line"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hw/hdmi_pixel_out.sv ====
`timescale 1ns/10ps

module hdmi_pixel_out (
    input  logic                      pixclk,
    input  logic                      reset,
    input  logic                      hsync,
    input  logic                      vsync,
    input  logic                      de,
    input  scope_display_pkg::pixel_t rgb,
    // parallel video to the transmitter
    output logic                      hs_out,
    output logic                      vs_out,
    output logic                      de_out,
    output logic [7:0]                r_out,
    output logic [7:0]                g_out,
    output logic [7:0]                b_out
);

    import scope_display_pkg::*;

    // captured colour word
    pixel_t rgb_q;

    ////////////////////
    // output register
    always_ff @(posedge pixclk) begin
        if (reset) begin
            hs_out <= 1'b0;
            vs_out <= 1'b0;
            de_out <= 1'b0;
        end else begin
            hs_out <= hsync;
            vs_out <= vsync;
            de_out <= de;
        end
    end

    always_ff @(posedge pixclk) begin
        rgb_q <= rgb;
    end

    // fields left aligned, low bits zero, blank outside de
    assign r_out = de_out ? {rgb_q.fld.r, 3'b000} : 8'd0;
    assign g_out = de_out ? {rgb_q.fld.g, 2'b00}  : 8'd0;
    assign b_out = de_out ? {rgb_q.fld.b, 3'b000} : 8'd0;

endmodule

// ==== hw/hdmi_top.sv ====
`timescale 1ns/10ps
`include "scope_display_params.svh"

module hdmi_top (
    input  logic       sys_clk,
    input  logic       reset,
    // sample stream
    input  logic       sample_valid,
    input  logic [7:0] sample_data,
    output logic       buffer_full,
    // hdmi parallel video
    output logic       pixclk_out,
    output logic       hs_out,
    output logic       vs_out,
    output logic       de_out,
    output logic [7:0] r_out,
    output logic [7:0] g_out,
    output logic [7:0] b_out
);

    import scope_display_pkg::*;

    // memory read port
    logic               ram_rd_en;
    logic               ram_rd_over;
    logic [`ADDR_W-1:0] wave_rd_addr;
    logic [7:0]         wave_rd_data;

    // raster to picture
    logic [9:0]         pix_x;
    logic [9:0]         pix_y;
    pixel_t             pix_data;

    // timing to output stage
    logic               hsync;
    logic               vsync;
    logic               rgb_valid;
    pixel_t             rgb;

    ////////////////////
    // input side
    wave_sample_buffer u_wave_sample_buffer (
        .sys_clk      (sys_clk),
        .reset        (reset),
        .sample_valid (sample_valid),
        .sample_data  (sample_data),
        .ram_rd_en    (ram_rd_en),
        .wave_rd_addr (wave_rd_addr),
        .ram_rd_over  (ram_rd_over),
        .wave_rd_data (wave_rd_data),
        .buffer_full  (buffer_full)
    );

    ////////////////////
    // timing and picture
    vga_ctrl u_vga_ctrl (
        .vga_clk      (sys_clk),
        .reset        (reset),
        .pix_data     (pix_data),
        .pix_x        (pix_x),
        .pix_y        (pix_y),
        .hsync        (hsync),
        .vsync        (vsync),
        .rgb_valid    (rgb_valid),
        .ram_rd_en    (ram_rd_en),
        .wave_rd_addr (wave_rd_addr),
        .ram_rd_over  (ram_rd_over),
        .rgb          (rgb)
    );

    vga_pic u_vga_pic (
        .vga_clk      (sys_clk),
        .reset        (reset),
        .pix_x        (pix_x),
        .pix_y        (pix_y),
        .wave_rd_data (wave_rd_data),
        .pix_data_out (pix_data)
    );

    ////////////////////
    // output side
    hdmi_pixel_out u_hdmi_pixel_out (
        .pixclk (sys_clk),
        .reset  (reset),
        .hsync  (hsync),
        .vsync  (vsync),
        .de     (rgb_valid),
        .rgb    (rgb),
        .hs_out (hs_out),
        .vs_out (vs_out),
        .de_out (de_out),
        .r_out  (r_out),
        .g_out  (g_out),
        .b_out  (b_out)
    );

    // pixel clock is the system clock
    assign pixclk_out = sys_clk;

endmodule

// ==== hw/scope_display_params.svh ====
`ifndef SCOPE_DISPLAY_PARAMS_SVH
`define SCOPE_DISPLAY_PARAMS_SVH

////////////////////
// horizontal timing in pixel clocks
`define H_SYNC      96
`define H_BACK      48
`define H_ACTIVE    640
`define H_FRONT     16
`define H_TOTAL     800

// vertical timing in lines
`define V_SYNC      2
`define V_BACK      33
`define V_ACTIVE    480
`define V_FRONT     10
`define V_TOTAL     525

// first active column and row, first front porch line
`define H_ACT_START (`H_SYNC + `H_BACK)
`define V_ACT_START (`V_SYNC + `V_BACK)
`define V_FP_START  (`V_SYNC + `V_BACK + `V_ACTIVE)

////////////////////
// waveform window, active coordinates
`define WAVE_LEN    300
`define WAVE_X0     170
`define WAVE_Y0     112
`define WAVE_H      256
`define ADDR_W      9
`define GRID_STEP   32

// rgb565 colours
`define COLOR_TRACE 16'hFFE0
`define COLOR_GRID  16'h8410
`define COLOR_BG    16'h0000

`endif

// ==== hw/scope_display_pkg.sv ====
package scope_display_pkg;

    ////////////////////
    // rgb565 pixel

    // one 16-bit word seen two ways
    // raw for colour constants, fld when splitting per channel
    typedef union packed {
        // whole word
        logic [15:0] raw;
        // channel view, red in the top bits
        struct packed {
            // red, 5 bits
            logic [4:0] r;
            // green, 6 bits
            logic [5:0] g;
            // blue, 5 bits
            logic [4:0] b;
        } fld;
    } pixel_t;

endpackage

// ==== hw/vga_ctrl.sv ====
`timescale 1ns/10ps
`include "scope_display_params.svh"

module vga_ctrl (
    input  logic                      vga_clk,
    input  logic                      reset,
    // pixel from the picture generator, same cycle as pix_x/pix_y
    input  scope_display_pkg::pixel_t pix_data,
    output logic [9:0]                pix_x,
    output logic [9:0]                pix_y,
    // video towards the output stage
    output logic                      hsync,
    output logic                      vsync,
    output logic                      rgb_valid,
    // waveform memory read port
    output logic                      ram_rd_en,
    output logic [`ADDR_W-1:0]        wave_rd_addr,
    output logic                      ram_rd_over,
    output scope_display_pkg::pixel_t rgb
);

    // raster position, zero is start of sync
    logic [9:0] cnt_h;
    logic [9:0] cnt_v;

    // decode of the current position
    logic       h_active;
    logic       v_active;
    logic       win_col;
    logic [9:0] rd_col;

    // first pipeline stage, lined up with the read data
    logic       hs_d1;
    logic       vs_d1;
    logic       de_d1;

    ////////////////////
    // raster counters

    always_ff @(posedge vga_clk) begin
        if (reset) begin
            cnt_h <= '0;
            cnt_v <= '0;
        end else if (cnt_h == 10'(`H_TOTAL - 1)) begin
            cnt_h <= '0;
            // wrap at end of frame
            if (cnt_v == 10'(`V_TOTAL - 1)) begin
                cnt_v <= '0;
            end else begin
                cnt_v <= cnt_v + 10'd1;
            end
        end else begin
            cnt_h <= cnt_h + 10'd1;
        end
    end

    // visible area
    assign h_active = (cnt_h >= 10'(`H_ACT_START))
                   && (cnt_h < 10'(`H_ACT_START + `H_ACTIVE));
    assign v_active = (cnt_v >= 10'(`V_ACT_START))
                   && (cnt_v < 10'(`V_ACT_START + `V_ACTIVE));

    ////////////////////
    // waveform read, one cycle ahead of the pixel

    assign win_col = (cnt_h >= 10'(`H_ACT_START + `WAVE_X0))
                  && (cnt_h < 10'(`H_ACT_START + `WAVE_X0 + `WAVE_LEN));
    assign rd_col  = cnt_h - 10'(`H_ACT_START + `WAVE_X0);

    assign ram_rd_en    = v_active && win_col;
    // sample index is the column inside the window
    assign wave_rd_addr = rd_col[`ADDR_W-1:0];

    // first clock of the vertical front porch
    assign ram_rd_over = (cnt_v == 10'(`V_FP_START)) && (cnt_h == 10'd0);

    ////////////////////
    // stage 1, same cycle as wave_rd_data

    always_ff @(posedge vga_clk) begin
        if (reset) begin
            hs_d1 <= 1'b0;
            vs_d1 <= 1'b0;
            de_d1 <= 1'b0;
            pix_x <= '0;
            pix_y <= '0;
        end else begin
            hs_d1 <= cnt_h < 10'(`H_SYNC);
            vs_d1 <= cnt_v < 10'(`V_SYNC);
            de_d1 <= h_active && v_active;
            // coordinates read as zero outside the visible area
            pix_x <= h_active ? cnt_h - 10'(`H_ACT_START) : 10'd0;
            // row held for the whole line
            pix_y <= v_active ? cnt_v - 10'(`V_ACT_START) : 10'd0;
        end
    end

    // stage 2, syncs and enable travel with the pixel
    always_ff @(posedge vga_clk) begin
        if (reset) begin
            hsync     <= 1'b0;
            vsync     <= 1'b0;
            rgb_valid <= 1'b0;
        end else begin
            hsync     <= hs_d1;
            vsync     <= vs_d1;
            rgb_valid <= de_d1;
        end
    end

    // colour word
    always_ff @(posedge vga_clk) begin
        rgb <= pix_data;
    end

endmodule

// ==== hw/vga_pic.sv ====
`timescale 1ns/10ps
`include "scope_display_params.svh"

module vga_pic (
    input  logic                      vga_clk,
    input  logic                      reset,
    // active coordinates, aligned with the sample
    input  logic [9:0]                pix_x,
    input  logic [9:0]                pix_y,
    input  logic [7:0]                wave_rd_data,
    output scope_display_pkg::pixel_t pix_data_out
);

    // column terms, change every pixel
    logic [9:0] col_off;
    logic       col_in_win;
    logic       col_grid;

    // row terms, pix_y is steady for the whole line
    logic [9:0] row_off;
    logic       row_in_win_q;
    logic       row_grid_q;
    logic [7:0] row_off_q;

    // trace row for this column, 255 at the bottom for sample 0
    logic [7:0] trace_row;

    ////////////////////
    // row decode

    assign row_off = pix_y - 10'(`WAVE_Y0);

    // registered once per pixel, long settled before column WAVE_X0
    always_ff @(posedge vga_clk) begin
        if (reset) begin
            row_in_win_q <= 1'b0;
            row_grid_q   <= 1'b0;
            row_off_q    <= '0;
        end else begin
            row_in_win_q <= (pix_y >= 10'(`WAVE_Y0))
                         && (pix_y < 10'(`WAVE_Y0 + `WAVE_H));
            row_grid_q   <= (row_off % `GRID_STEP) == 0;
            row_off_q    <= row_off[7:0];
        end
    end

    ////////////////////
    // column decode

    assign col_off    = pix_x - 10'(`WAVE_X0);
    assign col_in_win = (pix_x >= 10'(`WAVE_X0))
                     && (pix_x < 10'(`WAVE_X0 + `WAVE_LEN));
    assign col_grid   = (col_off % `GRID_STEP) == 0;

    // larger samples sit higher on screen
    assign trace_row = 8'(`WAVE_H - 1) - wave_rd_data;

    // colour pick, trace drawn over the grid
    always_comb begin
        pix_data_out.raw = `COLOR_BG;
        if (col_in_win && row_in_win_q) begin
            if (row_off_q == trace_row) begin
                pix_data_out.raw = `COLOR_TRACE;
            end else if (row_grid_q || col_grid) begin
                pix_data_out.raw = `COLOR_GRID;
            end
        end
    end

endmodule

// ==== hw/wave_sample_buffer.sv ====
`timescale 1ns/10ps
`include "scope_display_params.svh"

module wave_sample_buffer (
    input  logic                 sys_clk,
    input  logic                 reset,
    // capture side
    input  logic                 sample_valid,
    input  logic [7:0]           sample_data,
    // display side
    input  logic                 ram_rd_en,
    input  logic [`ADDR_W-1:0]   wave_rd_addr,
    input  logic                 ram_rd_over,
    output logic [7:0]           wave_rd_data,
    output logic                 buffer_full
);

    // two banks, one filling while the other is shown
    logic [7:0]         bank0 [0:`WAVE_LEN-1];
    logic [7:0]         bank1 [0:`WAVE_LEN-1];

    // bank being written, the display reads the other one
    logic               wr_bank;
    // next write slot, also the fill level
    logic [`ADDR_W-1:0] wr_addr;
    logic               wr_en;

    // strobes are dropped once the bank is full
    assign wr_en = sample_valid && !buffer_full;

    ////////////////////
    // fill and swap control

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            wr_bank     <= 1'b0;
            wr_addr     <= '0;
            buffer_full <= 1'b0;
        end else if (ram_rd_over && buffer_full) begin
            // frame done and a capture waits
            wr_bank     <= ~wr_bank;
            wr_addr     <= '0;
            buffer_full <= 1'b0;
        end else if (wr_en) begin
            wr_addr <= wr_addr + 1'b1;
            // last slot of the capture
            if (wr_addr == `ADDR_W'(`WAVE_LEN - 1)) begin
                buffer_full <= 1'b1;
            end
        end
    end

    ////////////////////
    // storage

    // sample lands on the edge after its strobe
    always_ff @(posedge sys_clk) begin
        if (wr_en) begin
            if (wr_bank) begin
                bank1[wr_addr] <= sample_data;
            end else begin
                bank0[wr_addr] <= sample_data;
            end
        end
    end

    // registered read of the display bank
    // data follows the address by one clock
    always_ff @(posedge sys_clk) begin
        if (ram_rd_en) begin
            if (wr_bank) begin
                wave_rd_data <= bank0[wave_rd_addr];
            end else begin
                wave_rd_data <= bank1[wave_rd_addr];
            end
        end
    end

endmodule

// ==== scope_display.f ====
+incdir+hw
hw/scope_display_pkg.sv
hw/wave_sample_buffer.sv
hw/vga_ctrl.sv
hw/vga_pic.sv
hw/hdmi_pixel_out.sv
hw/hdmi_top.sv
verification/clock_gen.sv
verification/scope_display_tb.sv

// ==== verification/clock_gen.sv ====
`timescale 1ns/10ps

module clock_gen (
    output logic clk,
    output logic reset
);

    ////////////////////
    // 100 ns pixel clock
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reset spans the first two rising edges
    // released just after the second one
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

// ==== verification/scope_display_tb.sv ====
`timescale 1ns/10ps
`include "scope_display_params.svh"

module scope_display_tb;

    // frames 0 to 4 plus margin for reset and slack
    localparam int CYCLE_LIMIT = 5 * `H_TOTAL * `V_TOTAL + 10000;

    logic clk, reset, sample_valid, buffer_full, pixclk_out, hs_out, vs_out, de_out;
    logic [7:0] sample_data, r_out, g_out, b_out;
    logic [23:0] act_rgb, exp_rgb;
    logic [31:0] lcg_state;
    // write bank as sent and capture currently on screen
    logic [7:0] wr_ref [0:`WAVE_LEN-1];
    logic [7:0] shown_ref [0:`WAVE_LEN-1];
    int wr_cnt, value_errs, other_errs, cycles, frames_done;
    int x_cnt, y_cnt, hs_run, vs_run, line_len;
    logic shown_ok, bf_exp, in_win, reset_q = 1'b0;
    logic de_q, hs_q, vs_q, hs_seen, vs_seen;
    logic pixclk_hi, pixclk_lo;

    clock_gen u_clock_gen (.clk(clk), .reset(reset));

    hdmi_top dut (
        .sys_clk(clk), .reset(reset), .sample_valid(sample_valid),
        .sample_data(sample_data), .buffer_full(buffer_full), .pixclk_out(pixclk_out),
        .hs_out(hs_out), .vs_out(vs_out), .de_out(de_out),
        .r_out(r_out), .g_out(g_out), .b_out(b_out)
    );

    // rgb565 to 8 bits per channel with low bits zero
    function automatic logic [23:0] expand565(input logic [15:0] c);
        return {c[15:11], 3'b000, c[10:5], 2'b00, c[4:0], 3'b000};
    endfunction

    localparam logic [23:0] TRACE_RGB = expand565(`COLOR_TRACE);

    // picture rule for one active pixel
    function automatic logic [23:0] expected_pixel(input int x, input int y);
        int col;
        int row;
        logic [15:0] c;
        c = `COLOR_BG;
        if (x >= `WAVE_X0 && x < `WAVE_X0 + `WAVE_LEN
                && y >= `WAVE_Y0 && y < `WAVE_Y0 + `WAVE_H) begin
            col = x - `WAVE_X0;
            row = y - `WAVE_Y0;
            // larger sample sits higher
            if (row == `WAVE_H - 1 - int'(shown_ref[col])) begin
                c = `COLOR_TRACE;
            end else if (col % `GRID_STEP == 0 || row % `GRID_STEP == 0) begin
                c = `COLOR_GRID;
            end
        end
        return expand565(c);
    endfunction

    // lcg step with bits 23:16 as the sample
    function automatic logic [7:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    task automatic log_mismatch(input string test, input int expected, input int actual);
        value_errs++;
        $display("** Error [%0t] %s: expected %0h, actual %0h", $time, test, expected, actual);
    endtask

    task automatic report_and_finish();
        $display("summary: %0d value errors, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    ////////////////////
    // scanner rebuilds position from the outputs
    assign act_rgb = {r_out, g_out, b_out};

    always_comb begin
        in_win = (x_cnt >= `WAVE_X0) && (x_cnt < `WAVE_X0 + `WAVE_LEN)
              && (y_cnt >= `WAVE_Y0) && (y_cnt < `WAVE_Y0 + `WAVE_H);
        exp_rgb = expected_pixel(x_cnt, y_cnt);
    end

    always @(posedge clk) begin
        reset_q <= reset;
        de_q <= de_out;
        hs_q <= hs_out;
        vs_q <= vs_out;
        if (reset) begin
            {x_cnt, y_cnt, hs_run, vs_run, line_len, frames_done} <= '0;
            {hs_seen, vs_seen} <= 2'b00;
        end else begin
            x_cnt <= de_out ? x_cnt + 1 : 0;
            hs_run <= hs_out ? hs_run + 1 : 0;
            vs_run <= vs_out ? vs_run + 1 : 0;
            line_len <= (hs_out && !hs_q) ? 1 : line_len + 1;
            hs_seen <= hs_seen || (hs_out && !hs_q);
            vs_seen <= vs_seen || (vs_out && !vs_q);
            if (vs_q && !vs_out) begin
                y_cnt <= 0;
            end else if (de_q && !de_out) begin
                y_cnt <= y_cnt + 1;
                // last active line done
                if (y_cnt == `V_ACTIVE - 1) frames_done <= frames_done + 1;
            end
        end
    end

    // pixel clock probed mid phase
    // high a quarter period after the rise, low a quarter after the fall
    always @(posedge clk) begin
        #25;
        pixclk_hi = pixclk_out;
        #50;
        pixclk_lo = pixclk_out;
    end

    ////////////////////
    // checks
    idle_chk: assert property (@(posedge clk) reset_q |->
            !hs_out && !vs_out && !de_out && !buffer_full)
        else log_mismatch("reset_idle", 0, int'($sampled({hs_out, vs_out, de_out, buffer_full})));
    blank_chk: assert property (@(posedge clk) disable iff (reset) !de_out |-> act_rgb == 0)
        else log_mismatch("reset_idle", 0, int'($sampled(act_rgb)));
    clk_out_chk: assert property (@(posedge clk) disable iff (reset) pixclk_hi && !pixclk_lo)
        else log_mismatch("pixel_clock", 2, int'($sampled({pixclk_hi, pixclk_lo})));
    de_len_chk: assert property (@(posedge clk) disable iff (reset)
            (de_q && !de_out) |-> x_cnt == `H_ACTIVE)
        else log_mismatch("frame_geometry", `H_ACTIVE, $sampled(x_cnt));
    lines_chk: assert property (@(posedge clk) disable iff (reset)
            (vs_out && !vs_q && vs_seen) |-> y_cnt == `V_ACTIVE)
        else log_mismatch("frame_geometry", `V_ACTIVE, $sampled(y_cnt));
    hs_len_chk: assert property (@(posedge clk) disable iff (reset)
            (hs_q && !hs_out) |-> hs_run == `H_SYNC)
        else log_mismatch("frame_geometry", `H_SYNC, $sampled(hs_run));
    period_chk: assert property (@(posedge clk) disable iff (reset)
            (hs_out && !hs_q && hs_seen) |-> line_len == `H_TOTAL)
        else log_mismatch("frame_geometry", `H_TOTAL, $sampled(line_len));
    vs_len_chk: assert property (@(posedge clk) disable iff (reset)
            (vs_q && !vs_out) |-> vs_run == `V_SYNC * `H_TOTAL)
        else log_mismatch("frame_geometry", `V_SYNC * `H_TOTAL, $sampled(vs_run));
    // vsync starts together with a line
    vs_edge_chk: assert property (@(posedge clk) disable iff (reset)
            (vs_out && !vs_q) |-> (hs_out && !hs_q))
        else log_mismatch("frame_geometry", 1, int'($sampled(hs_out)));
    outside_chk: assert property (@(posedge clk) disable iff (reset)
            (de_out && !in_win) |-> act_rgb == 0)
        else log_mismatch("background_and_grid", 0, int'($sampled(act_rgb)));
    grid_chk: assert property (@(posedge clk) disable iff (reset)
            (de_out && in_win && shown_ok && exp_rgb != TRACE_RGB && act_rgb != TRACE_RGB)
            |-> act_rgb == exp_rgb)
        else log_mismatch("background_and_grid", int'($sampled(exp_rgb)),
                          int'($sampled(act_rgb)));
    trace_chk: assert property (@(posedge clk) disable iff (reset)
            (de_out && in_win && shown_ok && (exp_rgb == TRACE_RGB || act_rgb == TRACE_RGB))
            |-> act_rgb == exp_rgb)
        else log_mismatch("trace_position", int'($sampled(exp_rgb)), int'($sampled(act_rgb)));
    // sampled at each line start away from the strobe bursts
    full_chk: assert property (@(posedge clk) disable iff (reset)
            (de_out && !de_q) |-> buffer_full == bf_exp)
        else log_mismatch("double_buffering", int'($sampled(bf_exp)),
                          int'($sampled(buffer_full)));

    ////////////////////
    // stimulus
    task automatic wait_line_start(input int line);
        do @(posedge clk); while (!(de_out && !de_q && y_cnt == line));
    endtask

    // one strobe per clock
    // dropped ones stay out of the model
    task automatic send_burst(input int count);
        int i;
        logic [7:0] value;
        wait_line_start(100);
        #1;
        for (i = 0; i < count; i++) begin
            value = lcg_next();
            sample_valid = 1'b1;
            sample_data = value;
            if (wr_cnt < `WAVE_LEN) begin
                wr_ref[wr_cnt] = value;
                wr_cnt++;
            end
            @(posedge clk);
            #1;
        end
        sample_valid = 1'b0;
        bf_exp = (wr_cnt == `WAVE_LEN);
    endtask

    // swap happens only with a complete write bank
    task automatic end_of_frame();
        int start;
        start = frames_done;
        while (frames_done == start) @(posedge clk);
        #1;
        if (wr_cnt == `WAVE_LEN) begin
            shown_ref = wr_ref;
            shown_ok = 1'b1;
            wr_cnt = 0;
            bf_exp = 1'b0;
        end
    endtask

    initial begin
        sample_valid = 1'b0;
        sample_data = 8'd0;
        lcg_state = 32'd20;
        {wr_cnt, value_errs, other_errs} = '0;
        {shown_ok, bf_exp} = 2'b00;
        @(negedge reset);
        // full capture while frame 0 is drawn
        send_burst(`WAVE_LEN);
        end_of_frame();
        // half capture in frame 1 so no swap
        send_burst(`WAVE_LEN / 2);
        end_of_frame();
        // frame 2 completes the bank and the rest is dropped
        send_burst(`WAVE_LEN);
        end_of_frame();
        // fresh capture in frame 3 after the clear
        send_burst(`WAVE_LEN);
        end_of_frame();
        end_of_frame();
        repeat (4) @(posedge clk);
        report_and_finish();
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            other_errs++;
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            report_and_finish();
        end
    end

    initial cycles = 0;

endmodule
